// File: acq_sequencer.sv
`timescale 1ns/1ns
`include "trig_macros.svh"

module acq_sequencer
    import trig_pkg::*;
(
    input  logic                            aclk,
    input  logic                            aresetn,
    input  trig_ctrl_t                      ctrl,
    input  trig_event_t                     event_in,
    input  logic [`TRIG_AXIS_DATA_W-1:0]    s_axis_tdata,
    input  logic                            s_axis_tvalid,
    input  logic                            m_axis_tready,
    output logic [`TRIG_AXIS_DATA_W-1:0]    m_axis_tdata,
    output logic                            m_axis_tvalid,
    output logic                            gate_out,
    output logic [`TRIG_ACQ_OUT_W-1:0]      acq_len_out,
    output trig_status_t                    status
);

    trig_state_e                    state_q;
    trig_state_e                    state_d;
    logic [`TRIG_AXIL_DATA_W-1:0]   acq_q;
    logic [`TRIG_AXIL_DATA_W-1:0]   count_q;
    logic [`TRIG_AXIL_DATA_W-1:0]   count_d;
    logic [`TRIG_AXIL_DATA_W-1:0]   acq_plus_one;
    logic [`TRIG_ACQ_OUT_W-1:0]     acq_len_out_q;
    logic                           gate_out_q;
    logic                           overflow_q;
    logic                           start;
    logic                           pass_samples;

    // Trigger only counts in idle with a non-zero length
    assign start = (state_q == st_idle) && event_in.trigger && (ctrl.acq_length != '0);

    // Frame length includes the timestamp word
    assign acq_plus_one = ctrl.acq_length + 1'b1;

    // Samples flow in data and in error
    assign pass_samples = (state_q == st_data) || (state_q == st_error);

    // --------------------------------------------------
    // Frame FSM
    // --------------------------------------------------
    always_comb
    begin
        state_d = state_q;
        count_d = count_q;
        case (state_q)
            st_idle:
            begin
                if (start)
                    state_d = st_timestamp;
            end
            st_timestamp:
            begin
                // Timestamp word taken, start counting samples
                if (m_axis_tready)
                begin
                    state_d = st_data;
                    count_d = '0;
                end
            end
            st_data:
            begin
                // Sink stalled while a sample arrives, sample is lost
                if (s_axis_tvalid && !m_axis_tready)
                    state_d = st_error;
                else if (s_axis_tvalid)
                begin
                    count_d = count_q + 1'b1;
                    // Last sample of the frame
                    if (count_d == acq_q)
                        state_d = st_idle;
                end
            end
            // Error is sticky until a reset
            default: state_d = st_error;
        endcase
    end

    always_ff @(posedge aclk)
    begin
        if (!aresetn || ctrl.soft_reset)
        begin
            state_q       <= st_idle;
            count_q       <= '0;
            acq_q         <= '0;
            acq_len_out_q <= '0;
            gate_out_q    <= 1'b0;
            overflow_q    <= 1'b0;
        end
        else
        begin
            state_q    <= state_d;
            count_q    <= count_d;
            // One cycle pulse on the edge into the timestamp state
            gate_out_q <= start;
            // Output side stall, registered
            overflow_q <= m_axis_tvalid && !m_axis_tready;
            // Length frozen for the whole frame
            if (start)
            begin
                acq_q         <= ctrl.acq_length;
                acq_len_out_q <= acq_plus_one[`TRIG_ACQ_OUT_W-1:0];
            end
        end
    end

    // --------------------------------------------------
    // Stream output
    // --------------------------------------------------
    // Timestamp word first, then the samples
    assign m_axis_tvalid = (state_q == st_timestamp) || (pass_samples && s_axis_tvalid);
    assign m_axis_tdata  = (state_q == st_timestamp) ? event_in.timestamp : s_axis_tdata;

    assign gate_out    = gate_out_q;
    assign acq_len_out = acq_len_out_q;

    // Status word, state in [15:8] and overflow in [7:0]
    always_comb
    begin
        status          = '0;
        status.state    = {6'b0, state_q};
        status.overflow = {7'b0, overflow_q};
    end

endmodule

// File: axil_regs.sv
`timescale 1ns/1ns
`include "trig_macros.svh"

module axil_regs
    import trig_pkg::*;
(
    input  logic                            aclk,
    input  logic                            aresetn,
    input  logic [`TRIG_AXIL_ADDR_W-1:0]    s_axil_awaddr,
    input  logic                            s_axil_awvalid,
    output logic                            s_axil_awready,
    input  logic [`TRIG_AXIL_DATA_W-1:0]    s_axil_wdata,
    input  logic [`TRIG_AXIL_DATA_W/8-1:0]  s_axil_wstrb,
    input  logic                            s_axil_wvalid,
    output logic                            s_axil_wready,
    output logic [1:0]                      s_axil_bresp,
    output logic                            s_axil_bvalid,
    input  logic                            s_axil_bready,
    input  logic [`TRIG_AXIL_ADDR_W-1:0]    s_axil_araddr,
    input  logic                            s_axil_arvalid,
    output logic                            s_axil_arready,
    output logic [`TRIG_AXIL_DATA_W-1:0]    s_axil_rdata,
    output logic [1:0]                      s_axil_rresp,
    output logic                            s_axil_rvalid,
    input  logic                            s_axil_rready,
    input  trig_status_t                    status,
    output trig_ctrl_t                      ctrl
);

    // Byte-lane merge of a write into a stored word
    function automatic logic [`TRIG_AXIL_DATA_W-1:0] merge_bytes(
        input logic [`TRIG_AXIL_DATA_W-1:0]   old_word,
        input logic [`TRIG_AXIL_DATA_W-1:0]   new_word,
        input logic [`TRIG_AXIL_DATA_W/8-1:0] strb
    );
        logic [`TRIG_AXIL_DATA_W-1:0] merged;
        merged = old_word;
        for (int i = 0; i < `TRIG_AXIL_DATA_W / 8; i++)
        begin
            if (strb[i])
                merged[8*i +: 8] = new_word[8*i +: 8];
        end
        return merged;
    endfunction

    logic                           wr_ready_q;
    logic                           bvalid_q;
    logic [`TRIG_ADDR_BITS-1:0]     wr_idx_q;
    logic                           wr_accept;
    logic                           wr_en;
    logic                           arready_q;
    logic                           rvalid_q;
    logic [`TRIG_ADDR_BITS-1:0]     rd_idx_q;
    logic [`TRIG_AXIL_DATA_W-1:0]   rdata_q;
    logic                           rd_accept;
    logic                           rd_en;
    logic [`TRIG_AXIL_DATA_W-1:0]   acq_reg;
    logic [`TRIG_AXIL_DATA_W-1:0]   srst_reg;
    reg_word_u                      rd_word;

    // --------------------------------------------------
    // Write channel
    // --------------------------------------------------
    // Address and data must arrive together, one write in flight
    assign wr_accept = !wr_ready_q && !bvalid_q && s_axil_awvalid && s_axil_wvalid;
    assign wr_en     = wr_ready_q && s_axil_awvalid && s_axil_wvalid;

    always_ff @(posedge aclk)
    begin
        if (!aresetn)
        begin
            wr_ready_q <= 1'b0;
            bvalid_q   <= 1'b0;
        end
        else
        begin
            // Ready is a single cycle pulse on both AW and W
            wr_ready_q <= wr_accept;
            if (wr_en)
                bvalid_q <= 1'b1;
            else if (s_axil_bready)
                bvalid_q <= 1'b0;
        end
    end

    // Word index captured with the address handshake
    always_ff @(posedge aclk)
    begin
        if (wr_accept)
            wr_idx_q <= s_axil_awaddr[`TRIG_ADDR_LSB +: `TRIG_ADDR_BITS];
    end

    // Writable registers, status and holes silently ignore writes
    always_ff @(posedge aclk)
    begin
        if (!aresetn)
        begin
            acq_reg  <= '0;
            srst_reg <= '0;
        end
        else if (wr_en)
        begin
            case (wr_idx_q)
                `TRIG_REG_ACQ:  acq_reg  <= merge_bytes(acq_reg, s_axil_wdata, s_axil_wstrb);
                `TRIG_REG_SRST: srst_reg <= merge_bytes(srst_reg, s_axil_wdata, s_axil_wstrb);
                default:        ;
            endcase
        end
    end

    // --------------------------------------------------
    // Read channel
    // --------------------------------------------------
    assign rd_accept = !arready_q && !rvalid_q && s_axil_arvalid;
    assign rd_en     = arready_q && s_axil_arvalid && !rvalid_q;

    always_ff @(posedge aclk)
    begin
        if (!aresetn)
        begin
            arready_q <= 1'b0;
            rvalid_q  <= 1'b0;
        end
        else
        begin
            arready_q <= rd_accept;
            if (rd_en)
                rvalid_q <= 1'b1;
            else if (s_axil_rready)
                rvalid_q <= 1'b0;
        end
    end

    // Read mux, status goes in through its own view
    always_comb
    begin
        rd_word.raw = '0;
        case (rd_idx_q)
            `TRIG_REG_ACQ:    rd_word.raw    = acq_reg;
            `TRIG_REG_SRST:   rd_word.raw    = srst_reg;
            `TRIG_REG_STATUS: rd_word.status = status;
            default:          rd_word.raw    = '0;
        endcase
    end

    always_ff @(posedge aclk)
    begin
        if (rd_accept)
            rd_idx_q <= s_axil_araddr[`TRIG_ADDR_LSB +: `TRIG_ADDR_BITS];
        // Data held until the next read is taken
        if (rd_en)
            rdata_q <= rd_word.raw;
    end

    // Outputs
    assign s_axil_awready = wr_ready_q;
    assign s_axil_wready  = wr_ready_q;
    assign s_axil_bvalid  = bvalid_q;
    assign s_axil_bresp   = 2'b00;
    assign s_axil_arready = arready_q;
    assign s_axil_rvalid  = rvalid_q;
    assign s_axil_rdata   = rdata_q;
    assign s_axil_rresp   = 2'b00;

    // Soft reset is bit 0 of its register
    assign ctrl = '{acq_length: acq_reg, soft_reset: srst_reg[0]};

endmodule

// File: axis_rx_trigger.sv
`timescale 1ns/1ns
`include "trig_macros.svh"

module axis_rx_trigger
    import trig_pkg::*;
(
    input  logic                            aclk,
    input  logic                            aresetn,
    input  logic                            timer_enable,
    input  logic                            gate,
    // Sample stream in, always accepted
    input  logic [`TRIG_AXIS_DATA_W-1:0]    s_axis_tdata,
    input  logic                            s_axis_tvalid,
    // Frame stream out
    output logic [`TRIG_AXIS_DATA_W-1:0]    m_axis_tdata,
    output logic                            m_axis_tvalid,
    input  logic                            m_axis_tready,
    // Register port
    input  logic [`TRIG_AXIL_ADDR_W-1:0]    s_axil_awaddr,
    input  logic                            s_axil_awvalid,
    output logic                            s_axil_awready,
    input  logic [`TRIG_AXIL_DATA_W-1:0]    s_axil_wdata,
    input  logic [`TRIG_AXIL_DATA_W/8-1:0]  s_axil_wstrb,
    input  logic                            s_axil_wvalid,
    output logic                            s_axil_wready,
    output logic [1:0]                      s_axil_bresp,
    output logic                            s_axil_bvalid,
    input  logic                            s_axil_bready,
    input  logic [`TRIG_AXIL_ADDR_W-1:0]    s_axil_araddr,
    input  logic                            s_axil_arvalid,
    output logic                            s_axil_arready,
    output logic [`TRIG_AXIL_DATA_W-1:0]    s_axil_rdata,
    output logic [1:0]                      s_axil_rresp,
    output logic                            s_axil_rvalid,
    input  logic                            s_axil_rready,
    // Trigger side outputs
    output logic                            resetn_out,
    output logic                            gate_out,
    output logic [`TRIG_ACQ_OUT_W-1:0]      acq_len_out
);

    trig_ctrl_t   ctrl;
    trig_status_t status;
    trig_event_t  trig_event;

    // Register block beside the pipeline
    axil_regs i_regs (
        .aclk           (aclk),
        .aresetn        (aresetn),
        .s_axil_awaddr  (s_axil_awaddr),
        .s_axil_awvalid (s_axil_awvalid),
        .s_axil_awready (s_axil_awready),
        .s_axil_wdata   (s_axil_wdata),
        .s_axil_wstrb   (s_axil_wstrb),
        .s_axil_wvalid  (s_axil_wvalid),
        .s_axil_wready  (s_axil_wready),
        .s_axil_bresp   (s_axil_bresp),
        .s_axil_bvalid  (s_axil_bvalid),
        .s_axil_bready  (s_axil_bready),
        .s_axil_araddr  (s_axil_araddr),
        .s_axil_arvalid (s_axil_arvalid),
        .s_axil_arready (s_axil_arready),
        .s_axil_rdata   (s_axil_rdata),
        .s_axil_rresp   (s_axil_rresp),
        .s_axil_rvalid  (s_axil_rvalid),
        .s_axil_rready  (s_axil_rready),
        .status         (status),
        .ctrl           (ctrl)
    );

    // Stage 1, gate edge and timestamp
    trig_front i_front (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .ctrl         (ctrl),
        .gate         (gate),
        .timer_enable (timer_enable),
        .event_out    (trig_event)
    );

    // Stage 2, frame sequencing onto the output stream
    acq_sequencer i_seq (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .ctrl          (ctrl),
        .event_in      (trig_event),
        .s_axis_tdata  (s_axis_tdata),
        .s_axis_tvalid (s_axis_tvalid),
        .m_axis_tready (m_axis_tready),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tvalid (m_axis_tvalid),
        .gate_out      (gate_out),
        .acq_len_out   (acq_len_out),
        .status        (status)
    );

    // Downstream reset follows both reset sources
    assign resetn_out = aresetn && !ctrl.soft_reset;

endmodule

// File: tb_axis_rx_trigger.sv
`timescale 1ns/1ns
`include "trig_macros.svh"

module tb_axis_rx_trigger;

    // Frames, gaps and register traffic fit well inside this
    localparam int cycle_limit = 4000;

    // Model FSM encoding, same values as the status register field
    localparam logic [1:0] ms_idle  = 2'd0;
    localparam logic [1:0] ms_stamp = 2'd1;
    localparam logic [1:0] ms_data  = 2'd2;
    localparam logic [1:0] ms_error = 2'd3;

    logic                            aclk;
    logic                            aresetn;
    logic                            timer_enable;
    logic                            gate;
    logic [`TRIG_AXIS_DATA_W-1:0]    s_axis_tdata;
    logic                            s_axis_tvalid;
    logic [`TRIG_AXIS_DATA_W-1:0]    m_axis_tdata;
    logic                            m_axis_tvalid;
    logic                            m_axis_tready;
    logic [`TRIG_AXIL_ADDR_W-1:0]    s_axil_awaddr;
    logic                            s_axil_awvalid;
    logic                            s_axil_awready;
    logic [`TRIG_AXIL_DATA_W-1:0]    s_axil_wdata;
    logic [`TRIG_AXIL_DATA_W/8-1:0]  s_axil_wstrb;
    logic                            s_axil_wvalid;
    logic                            s_axil_wready;
    logic [1:0]                      s_axil_bresp;
    logic                            s_axil_bvalid;
    logic                            s_axil_bready;
    logic [`TRIG_AXIL_ADDR_W-1:0]    s_axil_araddr;
    logic                            s_axil_arvalid;
    logic                            s_axil_arready;
    logic [`TRIG_AXIL_DATA_W-1:0]    s_axil_rdata;
    logic [1:0]                      s_axil_rresp;
    logic                            s_axil_rvalid;
    logic                            s_axil_rready;
    logic                            resetn_out;
    logic                            gate_out;
    logic [`TRIG_ACQ_OUT_W-1:0]      acq_len_out;

    // Stimulus state
    logic [31:0] lfsr_state;
    int          stream_mode;
    string       test_name;
    int          word_cnt;
    int          gate_cnt;
    int          cycle_cnt;

    // Model of registers, front end and frame sequencing
    logic [31:0] m_acq;
    logic [31:0] m_srst_reg;
    logic        m_srst;
    logic        mg1;
    logic        mg2;
    logic        mg3;
    logic        mtrig;
    logic [63:0] m_ts;
    logic [1:0]  m_state;
    logic [31:0] m_len;
    logic [31:0] m_cnt;
    logic        m_gate_out;
    logic [19:0] m_len_out;
    logic        m_start;
    logic        exp_valid;
    logic [63:0] exp_data;

    axis_rx_trigger i_dut (.*);

    bind axis_rx_trigger trig_props i_props (
        .aclk           (aclk),
        .aresetn        (aresetn),
        .gate_out       (gate_out),
        .s_axil_bvalid  (s_axil_bvalid),
        .s_axil_bready  (s_axil_bready),
        .s_axil_rvalid  (s_axil_rvalid),
        .s_axil_rready  (s_axil_rready),
        .m_axis_tvalid  (m_axis_tvalid)
    );

    initial
    begin
        aclk = 1'b0;
        forever #10 aclk = ~aclk;
    end

    // --------------------------------------------------
    // Random source and check helpers
    // --------------------------------------------------
    // 32-bit Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit taken
    task automatic random_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[62:0], lfsr_state[0]};
        end
    endtask

    task automatic check(input string what, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (actual !== expected)
        begin
            $display("FAILED %s %s expected %0h actual %0h", test_name, what, expected, actual);
            $display("test failed");
            $fatal(1);
        end
    endtask

    // Byte strobe applied to a stored word
    function automatic logic [31:0] apply_strobe(input logic [31:0] old_word,
                                                 input logic [31:0] new_word,
                                                 input logic [3:0] strb);
        logic [31:0] mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (old_word & ~mask) | (new_word & mask);
    endfunction

    // Falling edge step, the sample source is driven here
    task automatic tick();
        logic [63:0] r;
        @(negedge aclk);
        if (stream_mode == 0)
        begin
            s_axis_tvalid = 1'b0;
        end
        else
        begin
            random_bits(2, r);
            // Random mode is valid three cycles in four
            s_axis_tvalid = (stream_mode == 2) || (r[1:0] != 2'b00);
            random_bits(64, r);
            s_axis_tdata = r;
        end
    endtask

    task automatic wait_words(input int n);
        while (word_cnt < n)
            tick();
    endtask

    task automatic pulse_gate(input int width);
        tick();
        gate = 1'b1;
        repeat (width) tick();
        gate = 1'b0;
    endtask

    // --------------------------------------------------
    // AXI4-Lite master
    // --------------------------------------------------
    task automatic axil_write(input logic [3:0] idx, input logic [31:0] data,
                              input logic [3:0] strb);
        tick();
        s_axil_awaddr  = 16'(idx) << 2;
        s_axil_awvalid = 1'b1;
        s_axil_wdata   = data;
        s_axil_wstrb   = strb;
        s_axil_wvalid  = 1'b1;
        s_axil_bready  = 1'b0;
        while (!s_axil_awready)
            tick();
        // AW and W are taken together
        check("wready", 1'b1, s_axil_wready);
        // Register updates on this edge
        @(posedge aclk);
        if (idx == 4'd0)
            m_acq <= apply_strobe(m_acq, data, strb);
        else if (idx == 4'd1)
            m_srst_reg <= apply_strobe(m_srst_reg, data, strb);
        tick();
        s_axil_awvalid = 1'b0;
        s_axil_wvalid  = 1'b0;
        while (!s_axil_bvalid)
            tick();
        check("bresp", 2'b00, s_axil_bresp);
        // Response left waiting for a cycle before it is taken
        tick();
        s_axil_bready = 1'b1;
        tick();
        s_axil_bready = 1'b0;
    endtask

    task automatic axil_read(input logic [3:0] idx, output logic [31:0] data);
        tick();
        s_axil_araddr  = 16'(idx) << 2;
        s_axil_arvalid = 1'b1;
        s_axil_rready  = 1'b0;
        while (!s_axil_arready)
            tick();
        tick();
        s_axil_arvalid = 1'b0;
        while (!s_axil_rvalid)
            tick();
        data = s_axil_rdata;
        check("rresp", 2'b00, s_axil_rresp);
        // Read data left waiting for a cycle before it is taken
        tick();
        s_axil_rready = 1'b1;
        tick();
        s_axil_rready = 1'b0;
    endtask

    // Full frame with the sink always ready
    task automatic run_frame(input logic [31:0] n);
        axil_write(4'd0, n, 4'hf);
        word_cnt = 0;
        gate_cnt = 0;
        pulse_gate(3);
        wait_words(n + 1);
        // Settle long enough to catch extra words or pulses
        repeat (12) tick();
        check("word count", n + 1, word_cnt);
        check("gate_out pulses", 1, gate_cnt);
        check("acq_len_out", 20'(n + 1), acq_len_out);
    endtask

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------
    assign m_srst    = m_srst_reg[0];
    assign m_start   = (m_state == ms_idle) && mtrig && (m_acq != 32'd0);
    assign exp_valid = (m_state == ms_stamp) ||
                       (((m_state == ms_data) || (m_state == ms_error)) && s_axis_tvalid);
    assign exp_data  = (m_state == ms_stamp) ? m_ts : s_axis_tdata;

    always @(posedge aclk)
    begin
        if (!aresetn || m_srst)
        begin
            mg1        <= 1'b0;
            mg2        <= 1'b0;
            mg3        <= 1'b0;
            mtrig      <= 1'b0;
            m_ts       <= '0;
            m_state    <= ms_idle;
            m_len      <= '0;
            m_cnt      <= '0;
            m_gate_out <= 1'b0;
            m_len_out  <= '0;
        end
        else
        begin
            // Two flops of sync, then a one cycle rise pulse
            mg1        <= gate;
            mg2        <= mg1;
            mg3        <= mg2;
            mtrig      <= mg2 && !mg3;
            m_ts       <= timer_enable ? m_ts + 64'd1 : 64'd0;
            m_gate_out <= m_start;
            if (m_start)
            begin
                m_len     <= m_acq;
                m_len_out <= 20'(m_acq + 32'd1);
            end
            case (m_state)
                ms_idle:
                begin
                    if (m_start)
                        m_state <= ms_stamp;
                end
                ms_stamp:
                begin
                    if (m_axis_tready)
                    begin
                        m_state <= ms_data;
                        m_cnt   <= '0;
                    end
                end
                ms_data:
                begin
                    if (s_axis_tvalid && !m_axis_tready)
                        m_state <= ms_error;
                    else if (s_axis_tvalid)
                    begin
                        m_cnt <= m_cnt + 32'd1;
                        if (m_cnt + 32'd1 == m_len)
                            m_state <= ms_idle;
                    end
                end
                default: m_state <= ms_error;
            endcase
        end
    end

    // Cycle by cycle compare, values taken before the edge
    always @(posedge aclk)
    begin
        if (aresetn)
        begin
            check("m_axis_tvalid", exp_valid, m_axis_tvalid);
            if (exp_valid)
                check("m_axis_tdata", exp_data, m_axis_tdata);
            check("gate_out", m_gate_out, gate_out);
            check("acq_len_out", m_len_out, acq_len_out);
            check("resetn_out", !m_srst, resetn_out);
            if (m_axis_tvalid && m_axis_tready)
                word_cnt <= word_cnt + 1;
            if (gate_out)
                gate_cnt <= gate_cnt + 1;
        end
    end

    always @(posedge aclk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit)
        begin
            $display("Timeout, the run went past %0d clock cycles", cycle_limit);
            $display("test failed");
            $fatal(1);
        end
    end

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial
    begin
        logic [63:0] r;
        logic [63:0] s;
        logic [31:0] rd;
        logic [31:0] n;
        aresetn        = 1'b0;
        timer_enable   = 1'b1;
        gate           = 1'b0;
        s_axis_tdata   = '0;
        s_axis_tvalid  = 1'b0;
        m_axis_tready  = 1'b1;
        s_axil_awaddr  = '0;
        s_axil_awvalid = 1'b0;
        s_axil_wdata   = '0;
        s_axil_wstrb   = '0;
        s_axil_wvalid  = 1'b0;
        s_axil_bready  = 1'b0;
        s_axil_araddr  = '0;
        s_axil_arvalid = 1'b0;
        s_axil_rready  = 1'b0;
        lfsr_state     = 32'h58a5;
        stream_mode    = 0;
        m_acq          = '0;
        m_srst_reg     = '0;
        word_cnt       = 0;
        gate_cnt       = 0;
        cycle_cnt      = 0;
        test_name      = "reset";
        repeat (16) tick();
        aresetn = 1'b1;

        // Byte strobes merge into the length register
        test_name = "register_access";
        repeat (4)
        begin
            random_bits(32, r);
            random_bits(4, s);
            axil_write(4'd0, r[31:0], s[3:0]);
            axil_read(4'd0, rd);
            check("acq_length readback", m_acq, rd);
        end
        // Status is read only, holes read as zero
        axil_write(4'd2, 32'hffff_ffff, 4'hf);
        axil_read(4'd2, rd);
        check("status", 32'h0, rd);
        axil_read(4'd5, rd);
        check("undecoded read", 32'h0, rd);

        test_name   = "frame_content";
        stream_mode = 1;
        repeat (8)
        begin
            random_bits(3, r);
            run_frame(32'(r[2:0]) + 32'd1);
            random_bits(4, r);
            repeat (r[3:0]) tick();
        end

        test_name = "zero_length";
        axil_write(4'd0, 32'd0, 4'hf);
        word_cnt = 0;
        gate_cnt = 0;
        pulse_gate(3);
        repeat (12) tick();
        check("gate_out pulses", 0, gate_cnt);
        check("word count", 0, word_cnt);
        axil_read(4'd2, rd);
        check("status", 32'h0, rd);

        // Second rise lands while the frame waits for samples
        test_name = "gate_in_frame";
        random_bits(3, r);
        n = 32'(r[2:0]) + 32'd1;
        axil_write(4'd0, n, 4'hf);
        stream_mode = 0;
        word_cnt    = 0;
        gate_cnt    = 0;
        pulse_gate(3);
        wait_words(1);
        pulse_gate(3);
        repeat (6) tick();
        stream_mode = 1;
        wait_words(n + 1);
        repeat (12) tick();
        check("word count", n + 1, word_cnt);
        check("gate_out pulses", 1, gate_cnt);

        test_name = "error_and_soft_reset";
        random_bits(3, r);
        n = 32'(r[2:0]) + 32'd1;
        axil_write(4'd0, n, 4'hf);
        stream_mode = 0;
        word_cnt    = 0;
        gate_cnt    = 0;
        pulse_gate(3);
        wait_words(1);
        // Stall the sink under a solid sample stream
        m_axis_tready = 1'b0;
        stream_mode   = 2;
        repeat (4) tick();
        axil_read(4'd2, rd);
        check("status in error", 32'h0000_0301, rd);
        pulse_gate(3);
        repeat (8) tick();
        axil_read(4'd2, rd);
        check("status after gate", 32'h0000_0301, rd);
        check("gate_out pulses", 1, gate_cnt);
        axil_write(4'd1, 32'd1, 4'h1);
        check("resetn_out during soft reset", 1'b0, resetn_out);
        repeat (2) tick();
        axil_write(4'd1, 32'd0, 4'h1);
        check("resetn_out after soft reset", 1'b1, resetn_out);
        axil_read(4'd2, rd);
        check("status after soft reset", 32'h0, rd);
        m_axis_tready = 1'b1;
        stream_mode   = 1;
        random_bits(3, r);
        run_frame(32'(r[2:0]) + 32'd1);

        $display("test passed");
        $finish;
    end

endmodule

// File: trig_front.sv
`timescale 1ns/1ns
`include "trig_macros.svh"

module trig_front
    import trig_pkg::*;
(
    input  logic        aclk,
    input  logic        aresetn,
    input  trig_ctrl_t  ctrl,
    input  logic        gate,
    input  logic        timer_enable,
    output trig_event_t event_out
);

    logic                           gate_meta_q;
    logic                           gate_sync_q;
    logic                           gate_prev_q;
    logic                           trigger_q;
    logic                           timer_running_q;
    logic [`TRIG_AXIS_DATA_W-1:0]   timestamp_q;

    // --------------------------------------------------
    // Gate synchronizer and edge detect
    // --------------------------------------------------
    always_ff @(posedge aclk)
    begin
        if (!aresetn || ctrl.soft_reset)
        begin
            gate_meta_q     <= 1'b0;
            gate_sync_q     <= 1'b0;
            gate_prev_q     <= 1'b0;
            trigger_q       <= 1'b0;
            timer_running_q <= 1'b0;
            timestamp_q     <= '0;
        end
        else
        begin
            // Two stage synchronizer for the async gate
            gate_meta_q <= gate;
            gate_sync_q <= gate_meta_q;
            // History bit for the rising edge
            gate_prev_q <= gate_sync_q;
            trigger_q   <= gate_sync_q && !gate_prev_q;
            // Timer counts while enabled, sits at zero otherwise
            timer_running_q <= timer_enable;
            timestamp_q     <= timer_enable ? timestamp_q + 1'b1 : '0;
        end
    end

    // Registered stage output
    assign event_out = '{trigger: trigger_q, timestamp: timestamp_q,
                         timer_running: timer_running_q};

endmodule

// File: trig_macros.svh
`ifndef TRIG_MACROS_SVH
`define TRIG_MACROS_SVH

// --------------------------------------------------
// Register port geometry
// --------------------------------------------------
`define TRIG_AXIL_DATA_W 32
`define TRIG_AXIL_ADDR_W 16

// Stream word width, also used for the timestamp
`define TRIG_AXIS_DATA_W 64

// Width of the frame length sent downstream
`define TRIG_ACQ_OUT_W 20

// --------------------------------------------------
// Register map, as word indices
// --------------------------------------------------
`define TRIG_REG_ACQ 4'd0
`define TRIG_REG_SRST 4'd1
`define TRIG_REG_STATUS 4'd2

// Word address slice taken from the byte address
`define TRIG_ADDR_LSB 2
`define TRIG_ADDR_BITS 4

`endif

// File: trig_pkg.sv
`include "trig_macros.svh"

package trig_pkg;

    // Frame state, encoding is visible in the status register
    typedef enum logic [1:0] {
        st_idle      = 2'd0,
        st_timestamp = 2'd1,
        st_data      = 2'd2,
        st_error     = 2'd3
    } trig_state_e;

    // Control word from the register block to both stages
    typedef struct packed {
        logic [`TRIG_AXIL_DATA_W-1:0] acq_length;
        logic                         soft_reset;
    } trig_ctrl_t;

    // Status word layout at 0x08
    typedef struct packed {
        logic [15:0] reserved;
        logic [7:0]  state;
        logic [7:0]  overflow;
    } trig_status_t;

    // Read word, seen either as plain bits or as the status layout
    typedef union packed {
        logic [`TRIG_AXIL_DATA_W-1:0] raw;
        trig_status_t                 status;
    } reg_word_u;

    // Front end result handed to the sequencer
    typedef struct packed {
        logic                         trigger;
        logic [`TRIG_AXIS_DATA_W-1:0] timestamp;
        logic                         timer_running;
    } trig_event_t;

endpackage

// File: trig_props.sv
`timescale 1ns/1ns

module trig_props (
    input logic aclk,
    input logic aresetn,
    input logic gate_out,
    input logic s_axil_bvalid,
    input logic s_axil_bready,
    input logic s_axil_rvalid,
    input logic s_axil_rready,
    input logic m_axis_tvalid
);

    // Trigger pulse lasts one cycle
    a_gate_pulse: assert property (@(posedge aclk) disable iff (!aresetn)
        gate_out |=> !gate_out)
        else $error("gate_out high on two cycles in a row");

    // Write response held until taken
    a_bvalid_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid)
        else $error("BVALID dropped before BREADY");

    // Read data held until taken
    a_rvalid_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        s_axil_rvalid && !s_axil_rready |=> s_axil_rvalid)
        else $error("RVALID dropped before RREADY");

    // Quiet output once reset has taken hold
    a_tvalid_reset: assert property (@(posedge aclk)
        !aresetn && $past(!aresetn) |-> !m_axis_tvalid)
        else $error("m_axis_tvalid high during reset");

endmodule

// File: verilog.f
+incdir+.
trig_pkg.sv
axil_regs.sv
trig_front.sv
acq_sequencer.sv
axis_rx_trigger.sv
trig_props.sv
tb_axis_rx_trigger.sv
